//--- hdl/icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 cpu_req_i,
  input  wire icache_pkg::addr_t    match_adr_i,
  input  wire icache_pkg::way_vec_t hit_way_i,
  input  wire icache_pkg::way_vec_t victim_way_i,
  input  wire logic                 we_i,
  input  wire icache_pkg::addr_t    wradr_i,
  input  wire logic [15:0]          spr_bus_addr_i,
  input  wire logic                 spr_bus_we_i,
  input  wire logic                 spr_bus_stb_i,
  input  wire icache_pkg::word_t    spr_bus_dat_i,
  output icache_pkg::tag_op_e       tag_op_o,
  output icache_pkg::set_idx_t      wr_index_o,
  output icache_pkg::way_vec_t      wr_way_o,
  output logic                      refill_hit_o,
  output logic                      cpu_ack_o,
  output logic                      cache_hit_o,
  output logic                      refill_o,
  output logic                      refill_req_o,
  output logic                      refill_done_o,
  output logic                      invalidate_o,
  output logic                      spr_bus_ack_o
);

  import icache_pkg::*;

  icache_state_e                     state;
  icache_state_e                     state_next;
  logic                              read;
  logic                              refill;
  logic                              invalidate;
  logic                              hit;
  logic                              miss;
  logic                              spr_accept;
  logic                              first_strobe;
  logic                              refill_done;
  logic                              refill_hit;
  // Words of the refill line already in the RAM
  logic [WORDS_PER_LINE-1:0]         refill_valid;
  // Same, one cycle late to match the RAM read latency
  logic [WORDS_PER_LINE-1:0]         refill_valid_r;
  // Line address of the miss
  logic [ADDR_WIDTH-BLOCK_WIDTH-1:0] refill_line;
  set_idx_t                          inv_set;
  word_idx_t                         wr_word;
  word_idx_t                         next_word;
  word_idx_t                         match_word;

  assign read       = (state == READ);
  assign refill     = (state == REFILL);
  assign invalidate = (state == INVALIDATE);

  assign hit         = |hit_way_i;
  assign cache_hit_o = hit;

  ////////////////////////////////////////////////////////////
  // SPR invalidate decode
  ////////////////////////////////////////////////////////////

  assign invalidate_o = spr_bus_stb_i & spr_bus_we_i & (spr_bus_addr_i == SPR_ICBIR_ADDR);
  // Held strobe must not be taken twice
  assign spr_accept   = invalidate_o & ~refill & ~invalidate;

  // Invalidate wins over a miss in the same cycle
  assign miss = read & cpu_req_i & ~hit & ~spr_accept;

  ////////////////////////////////////////////////////////////
  // Refill tracking
  ////////////////////////////////////////////////////////////

  assign wr_word    = wradr_i[BLOCK_WIDTH-1:2];
  // Wraps inside the line
  assign next_word  = wr_word + 1'b1;
  assign match_word = match_adr_i[BLOCK_WIDTH-1:2];

  assign first_strobe = refill & we_i & (refill_valid == '0);
  // Next word already present means the line is complete
  assign refill_done  = refill & we_i & refill_valid[next_word];

  assign refill_hit = refill & refill_valid_r[match_word] &
                      (match_adr_i[ADDR_WIDTH-1:BLOCK_WIDTH] == refill_line);

  assign refill_done_o = refill_done;
  assign refill_hit_o  = refill_hit;

  assign cpu_ack_o    = cpu_req_i & ((read & hit) | refill_hit);
  assign refill_o     = refill;
  assign refill_req_o = miss | refill;

  // Data write goes to the victim on each strobe
  assign wr_way_o = {NUM_WAYS{refill & we_i}} & victim_way_i;

  ////////////////////////////////////////////////////////////
  // Tag RAM control
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (read) begin
      wr_index_o = match_adr_i[WAY_WIDTH-1:BLOCK_WIDTH];
    end else if (invalidate) begin
      wr_index_o = inv_set;
    end else begin
      wr_index_o = wradr_i[WAY_WIDTH-1:BLOCK_WIDTH];
    end
  end

  always_comb begin
    tag_op_o = TAG_NOP;
    case (state)
      READ: begin
        if (cpu_req_i & hit) begin
          tag_op_o = TAG_TOUCH;
        end else if (miss) begin
          tag_op_o = TAG_MISS;
        end
      end
      REFILL: begin
        if (first_strobe) begin
          tag_op_o = TAG_CLEAR_VICTIM;
        end else if (refill_done) begin
          tag_op_o = TAG_FILL;
        end
      end
      INVALIDATE: begin
        tag_op_o = TAG_CLEAR_SET;
      end
      default: begin
        tag_op_o = TAG_NOP;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Cache FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (cpu_req_i) begin
          state_next = READ;
        end
      end
      READ: begin
        if (!cpu_req_i) begin
          state_next = IDLE;
        end else if (miss) begin
          state_next = REFILL;
        end
      end
      REFILL: begin
        if (refill_done) begin
          state_next = IDLE;
        end
      end
      default: begin
        // INVALIDATE lasts one cycle
        state_next = IDLE;
      end
    endcase
    if (spr_accept) begin
      state_next = INVALIDATE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= IDLE;
      spr_bus_ack_o  <= 1'b0;
      refill_valid   <= '0;
      refill_valid_r <= '0;
    end else begin
      state          <= state_next;
      spr_bus_ack_o  <= spr_accept;
      refill_valid_r <= refill_valid;
      if (miss) begin
        refill_valid   <= '0;
        refill_valid_r <= '0;
      end else if (refill & we_i) begin
        refill_valid[wr_word] <= 1'b1;
      end
    end
  end

  // Line and set captured when the request is taken
  always_ff @(posedge clk) begin
    if (miss) begin
      refill_line <= match_adr_i[ADDR_WIDTH-1:BLOCK_WIDTH];
    end
    if (spr_accept) begin
      inv_set <= spr_bus_dat_i[WAY_WIDTH-1:BLOCK_WIDTH];
    end
  end

endmodule

`default_nettype wire

//--- hdl/icache_data_ways.sv
`timescale 1ns/10ps
`default_nettype none

module icache_data_ways (
  input  wire logic                 clk,
  input  wire icache_pkg::addr_t    rd_adr_i,
  input  wire icache_pkg::addr_t    wr_adr_i,
  input  wire icache_pkg::word_t    wr_dat_i,
  input  wire icache_pkg::way_vec_t wr_way_i,
  input  wire icache_pkg::way_vec_t hit_way_i,
  input  wire logic                 refill_hit_i,
  output icache_pkg::word_t         dat_o
);

  import icache_pkg::*;

  word_t    way_dout [NUM_WAYS];
  // Way written by the last refill strobe
  way_vec_t fill_way;
  way_vec_t sel_way;

  ////////////////////////////////////////////////////////////
  // Way RAMs
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    icache_dpram #(
      .addr_bits (RAM_ADDR_WIDTH),
      .data_bits (WORD_WIDTH)
    ) way_ram (
      .clk     (clk),
      .raddr_i (rd_adr_i[WAY_WIDTH-1:2]),
      .waddr_i (wr_adr_i[WAY_WIDTH-1:2]),
      .we_i    (wr_way_i[w]),
      .din_i   (wr_dat_i),
      .dout_o  (way_dout[w])
    );
  end

  // Remember the refill way between strobes
  always_ff @(posedge clk) begin
    if (|wr_way_i) begin
      fill_way <= wr_way_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output select
  ////////////////////////////////////////////////////////////

  // Early refill hit reads from the way being filled
  assign sel_way = refill_hit_i ? fill_way : hit_way_i;

  always_comb begin
    dat_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (sel_way[w]) begin
        dat_o = way_dout[w];
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/icache_dpram.sv
`timescale 1ns/10ps
`default_nettype none

module icache_dpram #(
  parameter int addr_bits = 6,
  parameter int data_bits = 32
) (
  input  wire logic                 clk,
  input  wire logic [addr_bits-1:0] raddr_i,
  input  wire logic [addr_bits-1:0] waddr_i,
  input  wire logic                 we_i,
  input  wire logic [data_bits-1:0] din_i,
  output logic      [data_bits-1:0] dout_o
);

  // Storage array
  logic [data_bits-1:0] mem [2**addr_bits];

  // Read every clock
  // A colliding write lands after the read, so old data comes out
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
    dout_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

//--- hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////

  localparam int WORD_WIDTH      = 32;
  localparam int ADDR_WIDTH      = 32;
  // 16-byte lines
  localparam int BLOCK_WIDTH     = 4;
  // 16 sets
  localparam int SET_WIDTH       = 4;
  // Bytes covered by one way
  localparam int WAY_WIDTH       = BLOCK_WIDTH + SET_WIDTH;
  localparam int TAG_WIDTH       = ADDR_WIDTH - WAY_WIDTH;
  localparam int NUM_WAYS        = 2;
  localparam int WORDS_PER_LINE  = 4;
  localparam int WORD_IDX_WIDTH  = BLOCK_WIDTH - 2;
  // Word address inside one way RAM
  localparam int RAM_ADDR_WIDTH  = WAY_WIDTH - 2;

  // Tag entry layout is {lru, way1 valid, way1 tag, way0 valid, way0 tag}
  localparam int WAY_ENTRY_WIDTH = TAG_WIDTH + 1;
  localparam int TAG_ENTRY_WIDTH = NUM_WAYS * WAY_ENTRY_WIDTH + 1;
  // LRU bit holds the index of the least recently used way
  localparam int LRU_BIT         = TAG_ENTRY_WIDTH - 1;

  // Block invalidate register on the SPR bus
  localparam logic [15:0] SPR_ICBIR_ADDR = 16'h2002;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [WORD_WIDTH-1:0]     word_t;
  typedef logic [SET_WIDTH-1:0]      set_idx_t;
  typedef logic [TAG_WIDTH-1:0]      tag_t;
  typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;
  typedef logic [NUM_WAYS-1:0]       way_vec_t;

  // Cache FSM states
  typedef enum logic [1:0] {
    IDLE,
    READ,
    REFILL,
    INVALIDATE
  } icache_state_e;

  // Tag RAM operations issued by the controller
  typedef enum logic [2:0] {
    TAG_NOP,
    TAG_TOUCH,
    TAG_MISS,
    TAG_CLEAR_VICTIM,
    TAG_FILL,
    TAG_CLEAR_SET
  } tag_op_e;

endpackage

`default_nettype wire

//--- hdl/icache_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array (
  input  wire logic                 clk,
  input  wire icache_pkg::set_idx_t rd_index_i,
  input  wire icache_pkg::set_idx_t wr_index_i,
  input  wire icache_pkg::tag_t     match_tag_i,
  input  wire icache_pkg::tag_t     fill_tag_i,
  input  wire icache_pkg::tag_op_e  tag_op_i,
  output icache_pkg::way_vec_t      hit_way_o,
  output icache_pkg::way_vec_t      victim_way_o
);

  import icache_pkg::*;

  // Entry read for the match address
  logic [TAG_ENTRY_WIDTH-1:0] tag_dout;
  // Entry to be written back
  logic [TAG_ENTRY_WIDTH-1:0] tag_din;
  // Copy of the set taken at the miss
  logic [TAG_ENTRY_WIDTH-1:0] saved_entry;
  logic                       tag_we;
  way_vec_t                   lru_way;
  way_vec_t                   victim_q;

  ////////////////////////////////////////////////////////////
  // Tag RAM
  ////////////////////////////////////////////////////////////

  icache_dpram #(
    .addr_bits (SET_WIDTH),
    .data_bits (TAG_ENTRY_WIDTH)
  ) tag_ram (
    .clk     (clk),
    .raddr_i (rd_index_i),
    .waddr_i (wr_index_i),
    .we_i    (tag_we),
    .din_i   (tag_din),
    .dout_o  (tag_dout)
  );

  ////////////////////////////////////////////////////////////
  // Hit compare and victim
  ////////////////////////////////////////////////////////////

  // Valid bit and tag compare per way
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_way_o[w] = tag_dout[w*WAY_ENTRY_WIDTH + TAG_WIDTH] &
                     (tag_dout[w*WAY_ENTRY_WIDTH +: TAG_WIDTH] == match_tag_i);
    end
  end

  // One-hot LRU way of the current entry
  assign lru_way = tag_dout[LRU_BIT] ? way_vec_t'(2'b10) : way_vec_t'(2'b01);

  // Victim and set contents are frozen at the miss
  always_ff @(posedge clk) begin
    if (tag_op_i == TAG_MISS) begin
      victim_q    <= lru_way;
      saved_entry <= tag_dout;
    end
  end

  assign victim_way_o = victim_q;

  ////////////////////////////////////////////////////////////
  // Entry update
  ////////////////////////////////////////////////////////////

  always_comb begin
    tag_din = tag_dout;
    tag_we  = 1'b0;
    case (tag_op_i)
      TAG_TOUCH: begin
        // Hit way becomes most recent, so the other one is LRU
        tag_din[LRU_BIT] = hit_way_o[0];
        tag_we           = 1'b1;
      end
      TAG_CLEAR_VICTIM: begin
        // Victim line is no longer trusted once refill starts
        tag_din = saved_entry;
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (victim_q[w]) begin
            tag_din[w*WAY_ENTRY_WIDTH + TAG_WIDTH] = 1'b0;
          end
        end
        tag_we = 1'b1;
      end
      TAG_FILL: begin
        // New tag with valid set
        tag_din = saved_entry;
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (victim_q[w]) begin
            tag_din[w*WAY_ENTRY_WIDTH +: WAY_ENTRY_WIDTH] = {1'b1, fill_tag_i};
          end
        end
        // Filled way is now the most recent
        tag_din[LRU_BIT] = victim_q[0];
        tag_we           = 1'b1;
      end
      TAG_CLEAR_SET: begin
        tag_din = '0;
        tag_we  = 1'b1;
      end
      default: begin
        // TAG_NOP and TAG_MISS leave the RAM alone
        tag_we = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              cpu_req_i,
  input  wire icache_pkg::addr_t cpu_adr_i,
  output logic                   cpu_ack_o,
  output icache_pkg::word_t      cpu_dat_o,
  input  wire logic              we_i,
  input  wire icache_pkg::addr_t wradr_i,
  input  wire icache_pkg::word_t wrdat_i,
  output logic                   refill_o,
  output logic                   refill_req_o,
  output logic                   refill_done_o,
  output logic                   invalidate_o,
  output logic                   cache_hit_o,
  input  wire logic [15:0]       spr_bus_addr_i,
  input  wire logic              spr_bus_we_i,
  input  wire logic              spr_bus_stb_i,
  input  wire icache_pkg::word_t spr_bus_dat_i,
  output logic                   spr_bus_ack_o
);

  import icache_pkg::*;

  // Fetch address of the previous cycle
  addr_t    match_adr;
  way_vec_t hit_way;
  way_vec_t victim_way;
  way_vec_t wr_way;
  tag_op_e  tag_op;
  set_idx_t wr_index;
  logic     refill_hit;

  // Lines up with the RAM read latency
  always_ff @(posedge clk) begin
    match_adr <= cpu_adr_i;
  end

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  icache_ctrl ctrl_inst (
    .clk            (clk),
    .rst            (rst),
    .cpu_req_i      (cpu_req_i),
    .match_adr_i    (match_adr),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .we_i           (we_i),
    .wradr_i        (wradr_i),
    .spr_bus_addr_i (spr_bus_addr_i),
    .spr_bus_we_i   (spr_bus_we_i),
    .spr_bus_stb_i  (spr_bus_stb_i),
    .spr_bus_dat_i  (spr_bus_dat_i),
    .tag_op_o       (tag_op),
    .wr_index_o     (wr_index),
    .wr_way_o       (wr_way),
    .refill_hit_o   (refill_hit),
    .cpu_ack_o      (cpu_ack_o),
    .cache_hit_o    (cache_hit_o),
    .refill_o       (refill_o),
    .refill_req_o   (refill_req_o),
    .refill_done_o  (refill_done_o),
    .invalidate_o   (invalidate_o),
    .spr_bus_ack_o  (spr_bus_ack_o)
  );

  // Tag read uses the live address, compare uses the registered one
  icache_tag_array tag_inst (
    .clk          (clk),
    .rd_index_i   (cpu_adr_i[WAY_WIDTH-1:BLOCK_WIDTH]),
    .wr_index_i   (wr_index),
    .match_tag_i  (match_adr[ADDR_WIDTH-1:WAY_WIDTH]),
    .fill_tag_i   (wradr_i[ADDR_WIDTH-1:WAY_WIDTH]),
    .tag_op_i     (tag_op),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  icache_data_ways data_inst (
    .clk          (clk),
    .rd_adr_i     (cpu_adr_i),
    .wr_adr_i     (wradr_i),
    .wr_dat_i     (wrdat_i),
    .wr_way_i     (wr_way),
    .hit_way_i    (hit_way),
    .refill_hit_i (refill_hit),
    .dat_o        (cpu_dat_o)
  );

endmodule

`default_nettype wire

//--- list.f
hdl/icache_pkg.sv
hdl/icache_dpram.sv
hdl/icache_tag_array.sv
hdl/icache_data_ways.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
verification/icache_chk.sv
verification/icache_tb.sv

//--- verification/icache_chk.sv
`timescale 1ns/10ps
`default_nettype none

module icache_chk (
  input wire logic clk,
  input wire logic rst,
  input wire logic cpu_req_i,
  input wire logic cpu_ack_i,
  input wire logic refill_i,
  input wire logic spr_bus_ack_i
);

  // Count of failed assertions
  int violations = 0;

  ////////////////////////////////////////////////////////////
  // Control output rules
  ////////////////////////////////////////////////////////////

  // Invalidate is never taken during a refill
  refill_spr_excl: assert property (@(posedge clk) disable iff (rst)
    !(refill_i && spr_bus_ack_i))
  else begin
    $error("refill and SPR acknowledge are high together");
    violations++;
  end

  // SPR acknowledge is a single-cycle pulse
  spr_ack_pulse: assert property (@(posedge clk) disable iff (rst)
    spr_bus_ack_i |=> !spr_bus_ack_i)
  else begin
    $error("SPR acknowledge lasted more than one cycle");
    violations++;
  end

  // No fetch acknowledge without a request held since the previous clock
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    cpu_ack_i |-> cpu_req_i && $past(cpu_req_i))
  else begin
    $error("fetch acknowledge without a fetch request");
    violations++;
  end

endmodule

bind icache_ctrl icache_chk chk_inst (
  .clk           (clk),
  .rst           (rst),
  .cpu_req_i     (cpu_req_i),
  .cpu_ack_i     (cpu_ack_o),
  .refill_i      (refill_o),
  .spr_bus_ack_i (spr_bus_ack_o)
);

`default_nettype wire

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int NUM_ROWS       = 21;
  localparam int TIMEOUT_CYCLES = 60 * NUM_ROWS;
  // Row layout is {op, expected hit, address}
  localparam logic OP_FETCH = 1'b0;
  localparam logic OP_INVAL = 1'b1;
  localparam logic EXP_MISS = 1'b0;
  localparam logic EXP_HIT  = 1'b1;
  // Memory word is its own byte address scrambled with this key
  localparam word_t DATA_KEY = 32'hC3A5_5A3C;

  logic        clk;
  logic        rst;
  logic        cpu_req;
  addr_t       cpu_adr;
  logic        cpu_ack;
  word_t       cpu_dat;
  logic        mem_we;
  addr_t       mem_adr;
  word_t       mem_dat;
  logic        refill;
  logic        refill_req;
  logic        refill_done;
  logic        invalidate;
  logic        cache_hit;
  logic [15:0] spr_addr;
  logic        spr_we;
  logic        spr_stb;
  word_t       spr_dat;
  logic        spr_ack;

  logic [33:0] rows [NUM_ROWS];
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;

  icache_top icache_top_inst (
    .clk            (clk),
    .rst            (rst),
    .cpu_req_i      (cpu_req),
    .cpu_adr_i      (cpu_adr),
    .cpu_ack_o      (cpu_ack),
    .cpu_dat_o      (cpu_dat),
    .we_i           (mem_we),
    .wradr_i        (mem_adr),
    .wrdat_i        (mem_dat),
    .refill_o       (refill),
    .refill_req_o   (refill_req),
    .refill_done_o  (refill_done),
    .invalidate_o   (invalidate),
    .cache_hit_o    (cache_hit),
    .spr_bus_addr_i (spr_addr),
    .spr_bus_we_i   (spr_we),
    .spr_bus_stb_i  (spr_stb),
    .spr_bus_dat_i  (spr_dat),
    .spr_bus_ack_o  (spr_ack)
  );

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("TEST FAILED");
    $finish;
  end

  // Contents of external memory
  function automatic word_t expected_word(input addr_t adr);
    return {adr[ADDR_WIDTH-1:2], 2'b00} ^ DATA_KEY;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Refill memory model
  ////////////////////////////////////////////////////////////

  // Writes the whole line from the missed word on, wrapping
  initial begin : refill_model
    addr_t     line_adr;
    word_idx_t start_word;
    word_idx_t word_sel;
    int        gap;
    mem_we  = 1'b0;
    mem_adr = '0;
    mem_dat = '0;
    gap     = $urandom(5);
    forever begin
      @(negedge clk);
      if (refill && !rst) begin
        line_adr   = {cpu_adr[ADDR_WIDTH-1:BLOCK_WIDTH], {BLOCK_WIDTH{1'b0}}};
        start_word = cpu_adr[BLOCK_WIDTH-1:2];
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
          word_sel = start_word + word_idx_t'(i);
          mem_we   = 1'b1;
          mem_adr  = line_adr | (addr_t'(word_sel) << 2);
          mem_dat  = expected_word(mem_adr);
          // Mid-cycle look at the done flag, only the last word completes the line
          #1;
          check_value("refill_done_o", refill_done, (i == WORDS_PER_LINE - 1));
          @(negedge clk);
          mem_we = 1'b0;
          // Idle gap of 0 to 2 cycles between strobes
          if (i < WORDS_PER_LINE - 1) begin
            gap = $urandom % 3;
            repeat (gap) @(negedge clk);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////

  task automatic fetch_word(input addr_t adr, input logic exp_hit);
    int   cycles;
    logic saw_req;
    logic first_hit;
    saw_req = 1'b0;
    cpu_req = 1'b1;
    cpu_adr = adr;
    @(negedge clk);
    cycles    = 1;
    // Tag compare of the first cycle in READ
    first_hit = cache_hit;
    while (!cpu_ack) begin
      if (refill_req) begin
        saw_req = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    check_value("cpu_dat_o", cpu_dat, expected_word(adr));
    check_value("cache_hit_o", first_hit, exp_hit);
    check_count++;
    if (exp_hit) begin
      if (cycles != 1) begin
        error_count++;
        $display("Fail at %0t: cpu_ack_o latency = %0d, expected 1", $time, cycles);
      end
      check_value("refill_req_o", refill_req, 0);
    end else if (!saw_req) begin
      error_count++;
      $display("Error: fetch of %h was acknowledged without a refill request", adr);
    end
    // Ack cycle ends at the next rising edge
    @(negedge clk);
    cpu_req = 1'b0;
    while (refill) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic invalidate_set(input addr_t adr);
    int cycles;
    spr_stb  = 1'b1;
    spr_we   = 1'b1;
    spr_addr = SPR_ICBIR_ADDR;
    spr_dat  = adr;
    cycles   = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!spr_ack);
    // Decode still sees the held strobe
    check_value("invalidate_o", invalidate, 1);
    spr_stb = 1'b0;
    spr_we  = 1'b0;
    // Cache is idle here, so the write is taken at once
    check_value("spr_bus_ack_o latency", cycles, 1);
    @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  // A, B and C share set 3
  task automatic load_table();
    rows[0]  = {OP_FETCH, EXP_MISS, 32'h0000_1034};
    rows[1]  = {OP_FETCH, EXP_HIT,  32'h0000_1038};
    rows[2]  = {OP_FETCH, EXP_HIT,  32'h0000_1030};
    rows[3]  = {OP_FETCH, EXP_HIT,  32'h0000_103C};
    rows[4]  = {OP_FETCH, EXP_MISS, 32'h0000_2030};
    rows[5]  = {OP_FETCH, EXP_HIT,  32'h0000_1034};
    rows[6]  = {OP_FETCH, EXP_MISS, 32'h0000_303C};
    rows[7]  = {OP_FETCH, EXP_HIT,  32'h0000_1038};
    rows[8]  = {OP_FETCH, EXP_MISS, 32'h0000_2034};
    rows[9]  = {OP_FETCH, EXP_HIT,  32'h0000_203C};
    rows[10] = {OP_FETCH, EXP_HIT,  32'h0000_1030};
    rows[11] = {OP_FETCH, EXP_MISS, 32'h0000_0548};
    rows[12] = {OP_FETCH, EXP_HIT,  32'h0000_0540};
    rows[13] = {OP_INVAL, EXP_MISS, 32'h0000_1030};
    rows[14] = {OP_FETCH, EXP_MISS, 32'h0000_1030};
    rows[15] = {OP_FETCH, EXP_MISS, 32'h0000_2038};
    rows[16] = {OP_FETCH, EXP_HIT,  32'h0000_054C};
    rows[17] = {OP_FETCH, EXP_MISS, 32'hFFFF_FF7C};
    rows[18] = {OP_FETCH, EXP_HIT,  32'hFFFF_FF70};
    rows[19] = {OP_INVAL, EXP_MISS, 32'h0000_0540};
    rows[20] = {OP_FETCH, EXP_MISS, 32'h0000_0544};
  endtask

  initial begin : main
    int total_errors;
    rst      = 1'b1;
    cpu_req  = 1'b0;
    cpu_adr  = '0;
    spr_addr = '0;
    spr_we   = 1'b0;
    spr_stb  = 1'b0;
    spr_dat  = '0;
    load_table();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    // Quiet outputs out of reset
    check_value("cpu_ack_o", cpu_ack, 0);
    check_value("refill_req_o", refill_req, 0);
    check_value("refill_o", refill, 0);
    check_value("spr_bus_ack_o", spr_ack, 0);
    // Tag RAM has no reset
    for (int s = 0; s < 2**SET_WIDTH; s++) begin
      invalidate_set(addr_t'(s) << BLOCK_WIDTH);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r][33] == OP_INVAL) begin
        invalidate_set(rows[r][31:0]);
      end else begin
        fetch_word(rows[r][31:0], rows[r][32]);
      end
    end
    total_errors = error_count + icache_top_inst.ctrl_inst.chk_inst.violations;
    $display("Checks: %0d, errors: %0d", check_count, total_errors);
    if (total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
